// ==== build.f ====
rtl/trace_cfg_pkg.sv
rtl/trace_types_pkg.sv
rtl/decode_align.sv
rtl/commit_queue.sv
rtl/commit_matcher.sv
rtl/trace_emitter.sv
rtl/commit_tracer.sv
test/commit_tracer_props.sv
test/commit_tracer_tb.sv

// ==== rtl/commit_matcher.sv ====
`timescale 1ns/10ps
`default_nettype none

module commit_matcher
  import trace_types_pkg::*;
(
  input logic head_v_i,
  input commit_entry_s head_i,
  input logic wb_v_i,
  input writeback_s wb_i,
  output logic pop_o,
  output logic retire_v_o,
  output commit_entry_s retire_entry_o,
  output writeback_s retire_wb_o
);

  logic wb_ready;
  logic retire;

  // the head is complete once its writeback, if any, is present.
  assign wb_ready = ~head_i.needs_wb | wb_v_i;
  assign retire = head_v_i & wb_ready;

  assign pop_o = retire;
  assign retire_v_o = retire;
  assign retire_entry_o = head_i;

  // a writeback seen with a no-writeback head is not paired with it.
  always_comb
  begin
    if (head_i.needs_wb)
      retire_wb_o = wb_i;
    else
      retire_wb_o = '0;
  end

endmodule

`default_nettype wire

// ==== rtl/commit_queue.sv ====
`timescale 1ns/10ps
`default_nettype none

module commit_queue
  import trace_cfg_pkg::*;
  import trace_types_pkg::*;
#(
  parameter int QUEUE_DEPTH = QUEUE_DEPTH_DEF
) (
  input logic clk_i,
  input logic rst_i,
  input logic push_i,
  input logic [VADDR_W-1:0] pc_i,
  input logic [INSTR_W-1:0] instr_i,
  input logic needs_wb_i,
  input logic pop_i,
  output logic head_v_o,
  output commit_entry_s head_o,
  output logic overflow_o
);

  localparam int PTR_W = $clog2(QUEUE_DEPTH);
  localparam int CNT_W = PTR_W + 1;
  localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(QUEUE_DEPTH);

  commit_entry_s mem_q [QUEUE_DEPTH];
  logic [PTR_W-1:0] rd_ptr_q;
  logic [PTR_W-1:0] wr_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic [ITAG_W-1:0] itag_q;
  logic overflow_q;

  logic full;
  logic do_push;
  logic do_pop;
  commit_entry_s entry;

  assign full = (count_q == FULL_CNT);
  assign do_pop = pop_i & (count_q != '0);
  assign do_push = push_i & (~full | do_pop); // a pop frees the slot in the same cycle.

  assign entry.pc = pc_i;
  assign entry.instr = instr_i;
  assign entry.itag = itag_q;
  assign entry.needs_wb = needs_wb_i;

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q <= '0;
      itag_q <= '0;
      overflow_q <= 1'b0;
    end
    else
    begin
      if (do_push)
        wr_ptr_q <= wr_ptr_q + PTR_W'(1); // wraps since the depth is a power of two.
      if (do_pop)
        rd_ptr_q <= rd_ptr_q + PTR_W'(1);
      if (do_push & ~do_pop)
        count_q <= count_q + CNT_W'(1);
      else if (do_pop & ~do_push)
        count_q <= count_q - CNT_W'(1);
      if (push_i)
        itag_q <= itag_q + ITAG_W'(1); // lost commits still consume a tag.
      if (push_i & ~do_push)
        overflow_q <= 1'b1; // sticky until reset.
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (do_push)
      mem_q[wr_ptr_q] <= entry;
  end

  assign head_v_o = (count_q != '0);
  assign head_o = mem_q[rd_ptr_q];
  assign overflow_o = overflow_q;

endmodule

`default_nettype wire

// ==== rtl/commit_tracer.sv ====
`timescale 1ns/10ps
`default_nettype none

module commit_tracer
  import trace_cfg_pkg::*;
  import trace_types_pkg::*;
#(
  parameter int unsigned HART_ID = HART_ID_DEF,
  parameter int DECODE_LAG = DECODE_LAG_DEF,
  parameter int QUEUE_DEPTH = QUEUE_DEPTH_DEF
) (
  input logic clk_i,
  input logic rst_i,
  input logic decode_v_i,
  input decode_flags_s decode_i,
  input logic commit_v_i,
  input logic [VADDR_W-1:0] commit_pc_i,
  input logic [INSTR_W-1:0] commit_instr_i,
  input logic wb_v_i,
  input writeback_s wb_i,
  output logic trace_v_o,
  output trace_rec_s trace_o,
  output logic overflow_o
);

  decode_flags_s flags_aligned;
  logic head_v;
  commit_entry_s head;
  logic pop;
  logic retire_v;
  commit_entry_s retire_entry;
  writeback_s retire_wb;

  decode_align #(
    .DECODE_LAG(DECODE_LAG)
  ) decode_align_i (
    .clk_i(clk_i),
    .rst_i(rst_i),
    .flags_v_i(decode_v_i),
    .flags_i(decode_i),
    .flags_o(flags_aligned)
  );

  commit_queue #(
    .QUEUE_DEPTH(QUEUE_DEPTH)
  ) commit_queue_i (
    .clk_i(clk_i),
    .rst_i(rst_i),
    .push_i(commit_v_i),
    .pc_i(commit_pc_i),
    .instr_i(commit_instr_i),
    .needs_wb_i(needs_wb(flags_aligned)),
    .pop_i(pop),
    .head_v_o(head_v),
    .head_o(head),
    .overflow_o(overflow_o)
  );

  commit_matcher commit_matcher_i (
    .head_v_i(head_v),
    .head_i(head),
    .wb_v_i(wb_v_i),
    .wb_i(wb_i),
    .pop_o(pop),
    .retire_v_o(retire_v),
    .retire_entry_o(retire_entry),
    .retire_wb_o(retire_wb)
  );

  trace_emitter #(
    .HART_ID(HART_ID)
  ) trace_emitter_i (
    .clk_i(clk_i),
    .rst_i(rst_i),
    .retire_v_i(retire_v),
    .retire_entry_i(retire_entry),
    .retire_wb_i(retire_wb),
    .trace_v_o(trace_v_o),
    .trace_o(trace_o)
  );

endmodule

`default_nettype wire

// ==== rtl/decode_align.sv ====
`timescale 1ns/10ps
`default_nettype none

module decode_align
  import trace_cfg_pkg::*;
  import trace_types_pkg::*;
#(
  parameter int DECODE_LAG = DECODE_LAG_DEF
) (
  input logic clk_i,
  input logic rst_i,
  input logic flags_v_i,
  input decode_flags_s flags_i,
  output decode_flags_s flags_o
);

  decode_flags_s [DECODE_LAG-1:0] stage_q;

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      stage_q <= '0;
    end
    else
    begin
      stage_q[0] <= flags_v_i ? flags_i : '0; // empty slots read as no writeback.
      for (int i = 1; i < DECODE_LAG; i++)
      begin
        stage_q[i] <= stage_q[i-1];
      end
    end
  end

  assign flags_o = stage_q[DECODE_LAG-1]; // lines up with commit_v_i.

endmodule

`default_nettype wire

// ==== rtl/trace_cfg_pkg.sv ====
`default_nettype none

package trace_cfg_pkg;

  // datapath widths of the traced rv64 hart.
  localparam int VADDR_W = 39; // sv39 virtual pc.
  localparam int INSTR_W = 32;
  localparam int DWORD_W = 64;
  localparam int REG_ADDR_W = 5; // x0 to x31.

  // trace bookkeeping widths.
  localparam int ITAG_W = 30; // wraps around after 2**30 commits.
  localparam int HART_W = 4;

  // default sizing for the tracer.
  localparam int unsigned HART_ID_DEF = 0;
  localparam int DECODE_LAG_DEF = 3; // decode to commit distance in cycles.
  localparam int QUEUE_DEPTH_DEF = 8; // must be a power of two.

endpackage

`default_nettype wire

// ==== rtl/trace_emitter.sv ====
`timescale 1ns/10ps
`default_nettype none

module trace_emitter
  import trace_cfg_pkg::*;
  import trace_types_pkg::*;
#(
  parameter int unsigned HART_ID = HART_ID_DEF
) (
  input logic clk_i,
  input logic rst_i,
  input logic retire_v_i,
  input commit_entry_s retire_entry_i,
  input writeback_s retire_wb_i,
  output logic trace_v_o,
  output trace_rec_s trace_o
);

  logic emit;
  trace_rec_s rec;
  logic trace_v_q;
  trace_rec_s trace_q;

  // zero pc commits are bubbles from the pipeline and are not traced.
  assign emit = retire_v_i & (retire_entry_i.pc != '0);

  assign rec.hart = HART_W'(HART_ID);
  assign rec.pc = retire_entry_i.pc;
  assign rec.instr = retire_entry_i.instr;
  assign rec.itag = retire_entry_i.itag;
  assign rec.rd_w_v = retire_entry_i.needs_wb;
  assign rec.rd_addr = retire_wb_i.rd_addr; // already zero for no-writeback heads.
  assign rec.rd_data = retire_wb_i.rd_data;

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
      trace_v_q <= 1'b0;
    else
      trace_v_q <= emit; // single cycle strobe per record.
  end

  always_ff @(posedge clk_i)
  begin
    if (emit)
      trace_q <= rec;
  end

  assign trace_v_o = trace_v_q;
  assign trace_o = trace_q;

endmodule

`default_nettype wire

// ==== rtl/trace_types_pkg.sv ====
`default_nettype none

package trace_types_pkg;

  import trace_cfg_pkg::*;

  typedef struct packed {
    logic irf_w_v; // writes an integer register.
    logic pipe_long_v; // result comes from a long latency pipe.
  } decode_flags_s;

  typedef struct packed {
    logic [VADDR_W-1:0] pc;
    logic [INSTR_W-1:0] instr;
    logic [ITAG_W-1:0] itag;
    logic needs_wb;
  } commit_entry_s;

  typedef struct packed {
    logic [REG_ADDR_W-1:0] rd_addr;
    logic [DWORD_W-1:0] rd_data;
  } writeback_s;

  typedef struct packed {
    logic [HART_W-1:0] hart;
    logic [VADDR_W-1:0] pc;
    logic [INSTR_W-1:0] instr;
    logic [ITAG_W-1:0] itag;
    logic rd_w_v;
    logic [REG_ADDR_W-1:0] rd_addr; // zero when rd_w_v is low.
    logic [DWORD_W-1:0] rd_data; // zero when rd_w_v is low.
  } trace_rec_s;

  // an instruction waits for a writeback if either pipe writes the register file.
  function automatic logic needs_wb(decode_flags_s flags);
    return flags.irf_w_v | flags.pipe_long_v;
  endfunction

endpackage

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the commit tracer testbench with Verilator.

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --assert --top-module commit_tracer_tb -f build.f \
  && ./obj_dir/Vcommit_tracer_tb > sim.log 2>&1 \
  || echo "build or simulation returned an error"

# The log decides the result.
if [ -f sim.log ]; then
  cat sim.log
fi
grep -q "TESTS PASSED" sim.log 2>/dev/null && exit 0 || exit 1

// ==== test/commit_tracer_props.sv ====
`timescale 1ns/10ps
`default_nettype none

module commit_tracer_props
  import trace_cfg_pkg::*;
(
  input logic clk_i,
  input logic rst_i,
  input logic head_v_i,
  input logic head_needs_wb_i,
  input logic [ITAG_W-1:0] head_itag_i,
  input logic wb_v_i,
  input logic pop_i,
  input logic overflow_i
);

  // a writeback is only meaningful for a head that waits for one.
  wb_has_taker: assert property (@(posedge clk_i) disable iff (rst_i)
    wb_v_i |-> (head_v_i && head_needs_wb_i))
    else $error("writeback arrived while the head was not waiting for one");

  // a head that is not popped keeps its place in the queue.
  head_holds: assert property (@(posedge clk_i) disable iff (rst_i)
    (head_v_i && !pop_i) |=> (head_v_i && $stable(head_itag_i)))
    else $error("commit queue head moved without a pop");

  no_overflow: assert property (@(posedge clk_i) disable iff (rst_i)
    !overflow_i)
    else $error("commit queue overflow flag went high");

endmodule

// sits on the wires between the commit queue and the matcher.
bind commit_tracer commit_tracer_props commit_tracer_props_i (
  .clk_i(clk_i),
  .rst_i(rst_i),
  .head_v_i(head_v),
  .head_needs_wb_i(head.needs_wb),
  .head_itag_i(head.itag),
  .wb_v_i(wb_v_i),
  .pop_i(pop),
  .overflow_i(overflow_o)
);

`default_nettype wire

// ==== test/commit_tracer_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module commit_tracer_tb
  import trace_cfg_pkg::*;
  import trace_types_pkg::*;
;

  localparam int unsigned HART_ID = 5;
  localparam int DECODE_LAG = 3;
  localparam int QUEUE_DEPTH = 8;
  localparam int MAX_OUTSTANDING = 6;
  localparam int DIRECTED_COMMITS = 14;
  localparam int RANDOM_COMMITS = 300;
  localparam int CYCLE_LIMIT = 40 * (DIRECTED_COMMITS + RANDOM_COMMITS) + 200;

  // one planned instruction, from decode to its writeback.
  typedef struct packed {
    logic [VADDR_W-1:0] pc;
    logic [INSTR_W-1:0] instr;
    decode_flags_s flags;
    logic [3:0] delay; // cycles the head waits before its writeback.
    writeback_s wb;
  } plan_s;

  logic clk_i = 1'b0;
  logic rst_i;
  logic decode_v_i;
  decode_flags_s decode_i;
  logic commit_v_i;
  logic [VADDR_W-1:0] commit_pc_i;
  logic [INSTR_W-1:0] commit_instr_i;
  logic wb_v_i;
  writeback_s wb_i;
  logic trace_v_o;
  trace_rec_s trace_o;
  logic overflow_o;

  int seed = 32'h31c7_c1a7;
  int cycle_cnt = 0;
  int commit_cyc = 0;
  int last_trace_cyc = 0;
  int rec_cnt = 0;
  int rd_idx = 0;
  int drop_idx = 0;
  int head_wait = 0;
  logic [ITAG_W-1:0] tag_cnt = '0;
  plan_s line [DECODE_LAG];
  logic [DECODE_LAG-1:0] line_v = '0;
  plan_s pend_q [$];
  trace_rec_s exp_q [$];

  commit_tracer #(
    .HART_ID(HART_ID),
    .DECODE_LAG(DECODE_LAG),
    .QUEUE_DEPTH(QUEUE_DEPTH)
  ) commit_tracer_i (
    .clk_i(clk_i),
    .rst_i(rst_i),
    .decode_v_i(decode_v_i),
    .decode_i(decode_i),
    .commit_v_i(commit_v_i),
    .commit_pc_i(commit_pc_i),
    .commit_instr_i(commit_instr_i),
    .wb_v_i(wb_v_i),
    .wb_i(wb_i),
    .trace_v_o(trace_v_o),
    .trace_o(trace_o),
    .overflow_o(overflow_o)
  );

  always #2 clk_i = ~clk_i;

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TESTS FAILED");
    $fatal(1, "run aborted");
  endtask

  task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp)
      abort_run($sformatf("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp));
  endtask

  function automatic logic flags_need_wb(decode_flags_s flags);
    return flags.irf_w_v | flags.pipe_long_v;
  endfunction

  // the record a commit should produce, built from the trace format rules.
  function automatic trace_rec_s expected_rec(input logic [VADDR_W-1:0] pc,
                                              input logic [INSTR_W-1:0] instr,
                                              input logic has_wb,
                                              input logic [ITAG_W-1:0] tag,
                                              input writeback_s wb);
    trace_rec_s rec;
    rec.hart = HART_W'(HART_ID);
    rec.pc = pc;
    rec.instr = instr;
    rec.itag = tag;
    rec.rd_w_v = has_wb;
    rec.rd_addr = has_wb ? wb.rd_addr : '0;
    rec.rd_data = has_wb ? wb.rd_data : '0;
    return rec;
  endfunction

  function automatic plan_s make_plan(input logic [VADDR_W-1:0] pc,
                                      input logic [INSTR_W-1:0] instr,
                                      input logic [1:0] flags,
                                      input logic [3:0] delay,
                                      input logic [REG_ADDR_W-1:0] rd_addr,
                                      input logic [DWORD_W-1:0] rd_data);
    plan_s p;
    p.pc = pc;
    p.instr = instr;
    p.flags = decode_flags_s'(flags);
    p.delay = delay;
    p.wb.rd_addr = rd_addr;
    p.wb.rd_data = rd_data;
    return p;
  endfunction

  function automatic plan_s random_plan();
    plan_s p;
    logic [31:0] r;
    logic [63:0] addr;
    r = $random(seed);
    addr = {$random(seed), $random(seed)};
    p.pc = (r[4:0] == 5'd0) ? '0 : addr[VADDR_W-1:0]; // about one in 32 is a bubble.
    p.instr = $random(seed);
    p.flags = r[5] ? decode_flags_s'((r[7:6] == 2'b00) ? 2'b10 : r[7:6]) : '0;
    p.delay = r[8] ? r[12:9] : 4'd0;
    p.wb.rd_addr = r[17:13];
    p.wb.rd_data = {$random(seed), $random(seed)};
    return p;
  endfunction

  function automatic int outstanding();
    return pend_q.size() + $countones(line_v);
  endfunction

  task automatic drive_idle();
    decode_v_i <= 1'b0;
    decode_i <= '0;
    commit_v_i <= 1'b0;
    commit_pc_i <= '0;
    commit_instr_i <= '0;
    wb_v_i <= 1'b0;
    wb_i <= '0;
  endtask

  // one clock of stimulus. the model of the queue decides when a writeback is due.
  task automatic step(input logic have_new, input plan_s p_new);
    plan_s head;
    plan_s cur;
    @(posedge clk_i);
    drive_idle();
    if (pend_q.size() != 0)
    begin
      head = pend_q[0];
      if (!flags_need_wb(head.flags))
      begin
        void'(pend_q.pop_front()); // retires in this cycle without help.
        head_wait = 0;
      end
      else if (head_wait >= int'(head.delay))
      begin
        wb_v_i <= 1'b1;
        wb_i <= head.wb;
        void'(pend_q.pop_front());
        head_wait = 0;
      end
      else
        head_wait++;
    end
    if (line_v[DECODE_LAG-1])
    begin
      cur = line[DECODE_LAG-1];
      commit_v_i <= 1'b1;
      commit_pc_i <= cur.pc;
      commit_instr_i <= cur.instr;
      pend_q.push_back(cur);
      if (cur.pc != '0)
        exp_q.push_back(expected_rec(cur.pc, cur.instr, flags_need_wb(cur.flags), tag_cnt, cur.wb));
      tag_cnt = tag_cnt + ITAG_W'(1); // bubbles use up a tag as well.
      commit_cyc = cycle_cnt + 1; // cycle_cnt still holds the previous cycle here.
    end
    for (int i = DECODE_LAG - 1; i > 0; i--)
      line[i] = line[i-1];
    line[0] = p_new;
    line_v = {line_v[DECODE_LAG-2:0], have_new};
    if (have_new)
    begin
      decode_v_i <= 1'b1;
      decode_i <= p_new.flags;
    end
  endtask

  task automatic drain();
    while (outstanding() != 0)
      step(1'b0, '0);
    repeat (3) step(1'b0, '0);
  endtask

  task automatic apply_reset(input int cycles);
    rst_i <= 1'b1;
    drive_idle();
    pend_q.delete();
    line_v = '0;
    head_wait = 0;
    tag_cnt = '0;
    drop_idx = exp_q.size(); // records still expected are lost with the reset.
    repeat (cycles) @(posedge clk_i);
    rst_i <= 1'b0;
  endtask

  always @(posedge clk_i)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT)
      abort_run("simulation timed out before all records arrived");
  end

  always @(negedge clk_i)
  begin
    if (rd_idx < drop_idx)
      rd_idx = drop_idx;
    if (trace_v_o)
    begin
      if (rd_idx >= exp_q.size())
        abort_run("trace_v_o rose while no record was expected");
      else
      begin
        check_val("trace_o.hart", 64'(trace_o.hart), 64'(exp_q[rd_idx].hart));
        check_val("trace_o.pc", 64'(trace_o.pc), 64'(exp_q[rd_idx].pc));
        check_val("trace_o.instr", 64'(trace_o.instr), 64'(exp_q[rd_idx].instr));
        check_val("trace_o.itag", 64'(trace_o.itag), 64'(exp_q[rd_idx].itag));
        check_val("trace_o.rd_w_v", 64'(trace_o.rd_w_v), 64'(exp_q[rd_idx].rd_w_v));
        check_val("trace_o.rd_addr", 64'(trace_o.rd_addr), 64'(exp_q[rd_idx].rd_addr));
        check_val("trace_o.rd_data", 64'(trace_o.rd_data), 64'(exp_q[rd_idx].rd_data));
        rd_idx++;
        rec_cnt++;
        last_trace_cyc = cycle_cnt;
      end
    end
  end

  initial
  begin
    int planned;
    logic [31:0] rnd;
    planned = 0;
    apply_reset(5);

    // a lone commit with no writeback.
    step(1'b1, make_plan(39'h00_8000_0000, 32'h0000_0013, 2'b00, 4'd0, 5'd0, 64'd0));
    drain();
    check_val("record count", 64'(rec_cnt), 64'd1);
    check_val("trace latency", 64'(last_trace_cyc - commit_cyc), 64'd2);

    // back to back writebacks with different delays.
    step(1'b1, make_plan(39'h00_8000_0004, 32'h0015_0513, 2'b10, 4'd0, 5'd10, 64'h1111_2222));
    step(1'b1, make_plan(39'h00_8000_0008, 32'h0025_8593, 2'b10, 4'd5, 5'd11, 64'hdead_beef));
    step(1'b1, make_plan(39'h00_8000_000c, 32'h0036_0613, 2'b11, 4'd2, 5'd12, 64'h0bad_f00d));
    drain();

    // the flags alone decide the wait.
    step(1'b1, make_plan(39'h00_8000_0010, 32'h0000_0013, 2'b00, 4'd0, 5'd7, 64'h7777));
    step(1'b1, make_plan(39'h00_8000_0014, 32'h0250_06b3, 2'b01, 4'd0, 5'd13, 64'h1313));
    step(1'b1, make_plan(39'h00_8000_0018, 32'h0000_0013, 2'b00, 4'd3, 5'd14, 64'h1414));
    drain();

    // a bubble between two commits still takes a tag.
    step(1'b1, make_plan(39'h00_8000_001c, 32'h0010_0093, 2'b00, 4'd0, 5'd0, 64'd0));
    step(1'b1, make_plan(39'h0, 32'h0000_0013, 2'b10, 4'd1, 5'd1, 64'h5a5a));
    step(1'b1, make_plan(39'h00_8000_0020, 32'h0020_0113, 2'b00, 4'd0, 5'd0, 64'd0));
    drain();

    // reset with writebacks still pending.
    step(1'b1, make_plan(39'h00_8000_0024, 32'h0030_0193, 2'b10, 4'd15, 5'd3, 64'h3333));
    step(1'b1, make_plan(39'h00_8000_0028, 32'h0040_0213, 2'b10, 4'd15, 5'd4, 64'h4444));
    step(1'b1, make_plan(39'h00_8000_002c, 32'h0050_0293, 2'b01, 4'd15, 5'd5, 64'h5555));
    while (line_v != '0)
      step(1'b0, '0);
    repeat (2) step(1'b0, '0);
    apply_reset(5);
    step(1'b1, make_plan(39'h00_8000_0100, 32'h0000_0013, 2'b00, 4'd0, 5'd0, 64'd0));
    drain();

    // random traffic with overlapping writebacks.
    while (planned < RANDOM_COMMITS)
    begin
      rnd = $random(seed);
      if (outstanding() < MAX_OUTSTANDING && rnd[1:0] != 2'b00)
      begin
        step(1'b1, random_plan());
        planned++;
      end
      else
        step(1'b0, '0);
    end
    drain();

    if (rd_idx < exp_q.size())
      abort_run("expected records were left over at the end of the run");
    else if (overflow_o)
      abort_run("overflow_o was set during the run");
    else
    begin
      $display("TESTS PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire
